//--- sources.f
source/fc_pkg.sv
source/fc_lane_if.sv
source/fc_weight_ram.sv
source/fc_loader.sv
source/fc_neuron.sv
source/fc_output_pack.sv
source/fc_layer.sv
sim/fc_layer_sva.sv
sim/tb_fc_layer.sv

//--- Makefile
# Verilator build and run of the FC layer testbench

TOP := tb_fc_layer

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP)

# Status comes from the search for the pass line in the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- sim/tb_fc_layer.sv
// Table-driven testbench for the FC layer, run as top with the bound output checks
`timescale 1ns/1ps

module tb_fc_layer;

    localparam int NUM_TESTS  = 11;
    localparam int NW         = fc_pkg::FRAME_WORDS;
    localparam int MAX_CYCLES = 40 * NUM_TESTS + 100;
    // Edges from last accepted word to the edge that raises t_valid
    localparam int LATENCY    = 22;

    logic        clk;
    logic        rstn;
    logic        r_valid;
    logic [31:0] in_data;
    logic        t_valid;
    logic [31:0] out_data;

    //////////////////////////////////////////////////////////////////////
    // Stimulus table, one row per test
    //////////////////////////////////////////////////////////////////////
    logic [31:0] frames [NUM_TESTS][NW];
    bit          gaps [NUM_TESTS];
    // Next frame follows with no idle cycle
    bit          chain [NUM_TESTS];
    logic [31:0] expected [NUM_TESTS];

    // Tests sent and not yet answered, and their last-word edges
    int pend_test [$];
    int accept_cyc [$];

    int cyc = 0;
    int word_seen = 0;
    int errors = 0;
    // Every t_valid pulse, matched to a frame or not
    int done_count = 0;
    int failed = 0;

    fc_layer u_dut (
        .clk      (clk),
        .rstn     (rstn),
        .r_valid  (r_valid),
        .in_data  (in_data),
        .t_valid  (t_valid),
        .out_data (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Bias plus exact dot product, shift by 8, clamp to a signed byte
    function automatic logic [31:0] reference_out(input int t);
        int acc;
        int x;
        int w;
        int y;
        logic [31:0] res;
        res = '0;
        for (int j = 0; j < 4; j++) begin
            acc = int'($signed(frames[t][NW-1][8*j +: 8]));
            for (int i = 0; i < 8; i++) begin
                x = int'($signed(frames[t][i/4][8*(i%4) +: 8]));
                w = int'($signed(frames[t][2+2*j+i/4][8*(i%4) +: 8]));
                acc += x * w;
            end
            y = acc >>> 8;
            if (y > 127) begin
                y = 127;
            end else if (y < -128) begin
                y = -128;
            end
            // Output 0 in the top byte
            res[8*(3-j) +: 8] = y[7:0];
        end
        return res;
    endfunction

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int w = 0; w < NW; w++) begin
                frames[t][w] = $urandom();
            end
            gaps[t]  = 1'b0;
            chain[t] = 1'b0;
        end
        // Zero features, biases +1 -1 +127 -128
        frames[0][0]  = '0;
        frames[0][1]  = '0;
        frames[0][10] = 32'h807f_ff01;
        // Tests 1 to 4 stay random
        // Same-sign maximum products
        for (int w = 0; w < 10; w++) begin
            frames[5][w] = 32'h7f7f_7f7f;
        end
        // Opposite-sign products
        frames[6][0] = 32'h7f7f_7f7f;
        frames[6][1] = 32'h7f7f_7f7f;
        for (int w = 2; w < 10; w++) begin
            frames[6][w] = 32'h8080_8080;
        end
        // Copy of test 1 sent with gaps
        for (int w = 0; w < NW; w++) begin
            frames[7][w] = frames[1][w];
        end
        gaps[7] = 1'b1;
        // Back-to-back chain 8..10 shares one weight set, features and biases differ
        for (int w = 2; w < 10; w++) begin
            frames[9][w]  = frames[8][w];
            frames[10][w] = frames[8][w];
        end
        chain[8] = 1'b1;
        chain[9] = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            expected[t] = reference_out(t);
        end
    endtask

    // One word per edge, idle cycles slipped in when gaps are on
    task automatic send_frame(input int t);
        pend_test.push_back(t);
        for (int w = 0; w < NW; w++) begin
            if (gaps[t] && ((w == 5) || ($urandom() % 4 == 0))) begin
                r_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            r_valid = 1'b1;
            in_data = frames[t][w];
            @(posedge clk);
            #1;
        end
        r_valid = 1'b0;
    endtask

    task automatic wait_results();
        while (pend_test.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Monitor, cycle count and timeout
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin : monitor
        int t;
        int acc_at;
        int err_before;
        cyc = cyc + 1;
        if (cyc > MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end else begin
            if (rstn && r_valid) begin
                word_seen = word_seen + 1;
                if (word_seen == NW) begin
                    word_seen = 0;
                    accept_cyc.push_back(cyc);
                end
            end
            if (t_valid) begin
                done_count++;
                if (pend_test.size() == 0 || accept_cyc.size() == 0) begin
                    $display("Error at %0d ns: t_valid with no frame outstanding", $time);
                    errors++;
                end else begin
                    t = pend_test.pop_front();
                    acc_at = accept_cyc.pop_front();
                    err_before = errors;
                    check_value("out_data", out_data, expected[t]);
                    // t_valid is seen one edge after it was registered
                    check_value("latency", cyc - acc_at - 1, LATENCY);
                    if (errors != err_before) begin
                        failed++;
                    end
                    $display("Test %0d %s: out_data %h", t,
                             (errors == err_before) ? "ok" : "wrong", out_data);
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h7140_2df5));
        rstn    = 1'b0;
        r_valid = 1'b0;
        in_data = '0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        #1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            send_frame(t);
            if (!chain[t]) begin
                wait_results();
            end
        end
        // Quiet window, a stray pulse from the last frame lands within one latency
        repeat (LATENCY) @(posedge clk);
        #1;
        check_value("t_valid count", done_count, NUM_TESTS);
        $display("Summary: %0d t_valid pulses, %0d tests wrong, %0d check errors",
                 done_count, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sim/fc_layer_sva.sv
// Concurrent checks on the FC layer output stream, attached to the top level with bind
`timescale 1ns/1ps

module fc_layer_sva (
    input logic        clk,
    input logic        rstn,
    input logic        t_valid,
    input logic [31:0] out_data
);

    //////////////////////////////////////////////////////////////////////
    // Output valid pulse
    //////////////////////////////////////////////////////////////////////

    // Single-cycle pulse, never two in a row
    assert property (@(posedge clk) disable iff (!rstn) t_valid |=> !t_valid)
        else $error("t_valid high on two consecutive cycles");

    // Quiet right after reset release
    assert property (@(posedge clk) $rose(rstn) |=> !t_valid)
        else $error("t_valid high in the cycle after reset release");

    //////////////////////////////////////////////////////////////////////
    // Output data
    //////////////////////////////////////////////////////////////////////

    // out_data and t_valid are registered on the same edge
    assert property (@(posedge clk) disable iff (!rstn) !$stable(out_data) |-> t_valid)
        else $error("out_data changed without t_valid");

endmodule

bind fc_layer fc_layer_sva u_sva (
    .clk      (clk),
    .rstn     (rstn),
    .t_valid  (t_valid),
    .out_data (out_data)
);

//--- source/fc_layer.sv
// Top level of the 8-in 4-out fully connected layer, stream words in and packed result bytes out
`timescale 1ns/1ps

module fc_layer (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      r_valid,
    input  logic [fc_pkg::WORD_W-1:0] in_data,
    output logic                      t_valid,
    output logic [fc_pkg::WORD_W-1:0] out_data
);

    // One lane bundle per output neuron
    fc_lane_if lane_if [fc_pkg::OUT_COUNT] ();

    // Frame receive, weight staging and lane load
    fc_loader u_loader (
        .clk     (clk),
        .rstn    (rstn),
        .r_valid (r_valid),
        .in_data (in_data),
        .lanes   (lane_if)
    );

    //////////////////////////////////////////////////////////////////////
    // Neuron lanes, all running in lockstep
    //////////////////////////////////////////////////////////////////////
    for (genvar j = 0; j < fc_pkg::OUT_COUNT; j++) begin : g_neuron
        fc_neuron u_neuron (
            .clk  (clk),
            .rstn (rstn),
            .lane (lane_if[j])
        );
    end

    // Result word and valid pulse
    fc_output_pack u_pack (
        .clk      (clk),
        .rstn     (rstn),
        .lanes    (lane_if),
        .t_valid  (t_valid),
        .out_data (out_data)
    );

endmodule

//--- source/fc_output_pack.sv
// Collects the lane result bytes into one output word and pulses t_valid for the stream sink
`timescale 1ns/1ps

module fc_output_pack (
    input  logic          clk,
    input  logic          rstn,
    fc_lane_if.pack       lanes [fc_pkg::OUT_COUNT],
    output logic          t_valid,
    output fc_pkg::word_t out_data
);

    // Result bytes pulled out of the interface array
    logic [fc_pkg::BYTE_W-1:0] res [fc_pkg::OUT_COUNT];

    // Lane 0 in the top byte, last lane at the bottom
    fc_pkg::word_t packed_res;

    // All lanes start and finish together, lane 0 stands for all
    logic done;

    for (genvar j = 0; j < fc_pkg::OUT_COUNT; j++) begin : g_res
        assign res[j] = lanes[j].result;
    end

    assign done = lanes[0].result_valid;

    always_comb begin
        packed_res = '0;
        for (int j = 0; j < fc_pkg::OUT_COUNT; j++) begin
            packed_res[(fc_pkg::OUT_COUNT-1-j)*fc_pkg::BYTE_W +: fc_pkg::BYTE_W] = res[j];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    // out_data holds until the next frame completes
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            t_valid  <= 1'b0;
            out_data <= '0;
        end else begin
            t_valid <= done;
            if (done) begin
                out_data <= packed_res;
            end
        end
    end

endmodule

//--- source/fc_neuron.sv
// One output lane, serial signed multiply-accumulate with bias add and saturating requantization
`timescale 1ns/1ps

module fc_neuron (
    input logic       clk,
    input logic       rstn,
    fc_lane_if.neuron lane
);

    fc_pkg::neuron_state_e state;

    // Products done so far in this frame
    logic [$clog2(fc_pkg::IN_COUNT)-1:0] mac_cnt;

    // Operand shift registers, byte 0 at the bottom
    fc_pkg::vec_t feat_sh;
    fc_pkg::vec_t wt_sh;
    logic signed [fc_pkg::BYTE_W-1:0] bias_q;

    // MAC path
    logic signed [fc_pkg::BYTE_W-1:0]   mac_a;
    logic signed [fc_pkg::BYTE_W-1:0]   mac_b;
    logic signed [2*fc_pkg::BYTE_W-1:0] product;
    fc_pkg::acc_t acc;
    fc_pkg::acc_t acc_base;
    fc_pkg::acc_t acc_next;

    // Quantize stage request and result
    logic quant_pend;
    logic result_valid_q;
    logic [fc_pkg::BYTE_W-1:0] result_q;

    // Arithmetic shift, then clamp to a signed byte
    function automatic logic [fc_pkg::BYTE_W-1:0] quantize(input fc_pkg::acc_t value);
        fc_pkg::acc_t shifted;
        shifted = value >>> fc_pkg::QUANT_SHIFT;
        if (shifted > (2 ** (fc_pkg::BYTE_W - 1)) - 1) begin
            return {1'b0, {(fc_pkg::BYTE_W - 1){1'b1}}};
        end else if (shifted < -(2 ** (fc_pkg::BYTE_W - 1))) begin
            return {1'b1, {(fc_pkg::BYTE_W - 1){1'b0}}};
        end
        return shifted[fc_pkg::BYTE_W-1:0];
    endfunction

    // First product taken straight from the lane on the load cycle
    always_comb begin
        mac_a    = lane.load ? lane.feature[fc_pkg::BYTE_W-1:0] : feat_sh[fc_pkg::BYTE_W-1:0];
        mac_b    = lane.load ? lane.weight_row[fc_pkg::BYTE_W-1:0] : wt_sh[fc_pkg::BYTE_W-1:0];
        product  = mac_a * mac_b;
        // Load restarts from zero
        acc_base = lane.load ? '0 : acc;
        acc_next = acc_base + product;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state          <= fc_pkg::IDLE;
            mac_cnt        <= '0;
            quant_pend     <= 1'b0;
            result_valid_q <= 1'b0;
        end else begin
            quant_pend     <= 1'b0;
            result_valid_q <= quant_pend;
            if (lane.load) begin
                state   <= fc_pkg::ACCUMULATE;
                mac_cnt <= 1'b1;
            end else begin
                case (state)
                    fc_pkg::ACCUMULATE: begin
                        mac_cnt <= mac_cnt + 1'b1;
                        if (mac_cnt == ($bits(mac_cnt))'(fc_pkg::IN_COUNT - 1)) begin
                            state <= fc_pkg::BIAS_ADD;
                        end
                    end
                    fc_pkg::BIAS_ADD: begin
                        state      <= fc_pkg::IDLE;
                        quant_pend <= 1'b1;
                    end
                    default: state <= fc_pkg::IDLE;
                endcase
            end
        end
    end

    // Operands shift down one byte per product
    always_ff @(posedge clk) begin
        if (lane.load) begin
            feat_sh <= lane.feature >> fc_pkg::BYTE_W;
            wt_sh   <= lane.weight_row >> fc_pkg::BYTE_W;
            bias_q  <= lane.bias;
            acc     <= acc_next;
        end else if (state == fc_pkg::ACCUMULATE) begin
            feat_sh <= feat_sh >> fc_pkg::BYTE_W;
            wt_sh   <= wt_sh >> fc_pkg::BYTE_W;
            acc     <= acc_next;
        end else if (state == fc_pkg::BIAS_ADD) begin
            acc <= acc + bias_q;
        end
        if (quant_pend) begin
            result_q <= quantize(acc);
        end
    end

    assign lane.result_valid = result_valid_q;
    assign lane.result       = result_q;

endmodule

//--- source/fc_loader.sv
// Frame receiver that stages weights in memory, reads them back and loads all neuron lanes at once
`timescale 1ns/1ps

module fc_loader (
    input  logic          clk,
    input  logic          rstn,
    input  logic          r_valid,
    input  fc_pkg::word_t in_data,
    fc_lane_if.loader     lanes [fc_pkg::OUT_COUNT]
);

    typedef logic [$clog2(fc_pkg::FRAME_WORDS)-1:0] cnt_t;

    fc_pkg::loader_state_e state;

    // Frame word position and decode
    cnt_t word_cnt;
    cnt_t weight_off;
    logic frame_end;
    logic weight_word;

    // Weight memory port
    logic          ram_rd_en;
    logic          ram_wr_en;
    fc_pkg::addr_t ram_addr;
    fc_pkg::word_t ram_wr_data;
    fc_pkg::word_t ram_rd_data;

    // Readback issue and return tracking
    fc_pkg::addr_t rd_cnt;
    fc_pkg::addr_t ret_cnt;
    logic [fc_pkg::MEM_LATENCY-1:0] ret_pipe;
    logic ret_capture;
    logic ret_last;

    // Weight words waiting for a free memory port
    logic [fc_pkg::WEIGHT_WORDS-1:0] pend_valid;
    fc_pkg::word_t pend_data [fc_pkg::WEIGHT_WORDS];
    fc_pkg::addr_t pend_pick;
    logic          write_go;

    // Feature and bias capture, then copies held for the lanes
    fc_pkg::vec_t  feature_reg;
    fc_pkg::vec_t  held_feature;
    fc_pkg::word_t held_bias;
    fc_pkg::vec_t  lane_feature;
    fc_pkg::word_t lane_bias;
    fc_pkg::word_t rows [fc_pkg::WEIGHT_WORDS];
    logic          load_q;

    fc_weight_ram u_weight_ram (
        .clk     (clk),
        .rstn    (rstn),
        .rd_en   (ram_rd_en),
        .wr_en   (ram_wr_en),
        .addr    (ram_addr),
        .wr_data (ram_wr_data),
        .rd_data (ram_rd_data)
    );

    // Word decode
    assign weight_off  = word_cnt - cnt_t'(fc_pkg::INPUT_WORDS);
    assign frame_end   = r_valid && (word_cnt == cnt_t'(fc_pkg::FRAME_WORDS - 1));
    assign weight_word = r_valid && (word_cnt >= cnt_t'(fc_pkg::INPUT_WORDS))
                         && (word_cnt < cnt_t'(fc_pkg::INPUT_WORDS + fc_pkg::WEIGHT_WORDS));

    // Read data is on the port once the issue has aged MEM_LATENCY edges
    assign ret_capture = ret_pipe[fc_pkg::MEM_LATENCY-1];
    assign ret_last    = ret_capture && (ret_cnt == fc_pkg::addr_t'(fc_pkg::WEIGHT_WORDS - 1));

    // Lowest pending address first, keeps writes ahead of the next readback
    always_comb begin
        pend_pick = '0;
        for (int k = fc_pkg::WEIGHT_WORDS - 1; k >= 0; k--) begin
            if (pend_valid[k]) begin
                pend_pick = fc_pkg::addr_t'(k);
            end
        end
    end
    assign write_go = (state != fc_pkg::READBACK) && (|pend_valid);

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= fc_pkg::RECEIVE;
            word_cnt   <= '0;
            rd_cnt     <= '0;
            ret_cnt    <= '0;
            ret_pipe   <= '0;
            pend_valid <= '0;
            ram_rd_en  <= 1'b0;
            ram_wr_en  <= 1'b0;
            ram_addr   <= '0;
            load_q     <= 1'b0;
        end else begin
            ram_rd_en <= 1'b0;
            ram_wr_en <= 1'b0;
            ret_pipe  <= {ret_pipe[fc_pkg::MEM_LATENCY-2:0], ram_rd_en};
            // One load pulse per completed readback
            load_q    <= ret_last;
            if (r_valid) begin
                word_cnt <= frame_end ? '0 : word_cnt + 1'b1;
            end
            // Wraps to zero after the last row word
            if (ret_capture) begin
                ret_cnt <= ret_cnt + 1'b1;
            end
            case (state)
                fc_pkg::READBACK: begin
                    // One read per cycle, addresses 0..7
                    ram_rd_en <= 1'b1;
                    ram_addr  <= rd_cnt;
                    rd_cnt    <= rd_cnt + 1'b1;
                    if (rd_cnt == fc_pkg::addr_t'(fc_pkg::WEIGHT_WORDS - 1)) begin
                        state <= fc_pkg::LOAD;
                    end
                end
                fc_pkg::LOAD: begin
                    if (ret_last) begin
                        state <= fc_pkg::RECEIVE;
                    end
                end
                default: state <= fc_pkg::RECEIVE;
            endcase
            // Drain one pending weight while no read is being issued
            if (write_go) begin
                ram_wr_en             <= 1'b1;
                ram_addr              <= pend_pick;
                pend_valid[pend_pick] <= 1'b0;
            end
            if (weight_word) begin
                pend_valid[fc_pkg::addr_t'(weight_off)] <= 1'b1;
            end
            // Next frame may close while the lanes are still being loaded
            if (frame_end) begin
                state  <= fc_pkg::READBACK;
                rd_cnt <= '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (r_valid && (word_cnt < cnt_t'(fc_pkg::INPUT_WORDS))) begin
            feature_reg[word_cnt * fc_pkg::WORD_W +: fc_pkg::WORD_W] <= in_data;
        end
        if (weight_word) begin
            pend_data[fc_pkg::addr_t'(weight_off)] <= in_data;
        end
        // Bias is the closing word, features are frozen alongside it
        if (frame_end) begin
            held_feature <= feature_reg;
            held_bias    <= in_data;
        end
        if (write_go) begin
            ram_wr_data <= pend_data[pend_pick];
        end
        if (ret_capture) begin
            rows[ret_cnt] <= ram_rd_data;
        end
        if (ret_last) begin
            lane_feature <= held_feature;
            lane_bias    <= held_bias;
        end
    end

    // Lane j takes words 2j and 2j+1 of the readback
    for (genvar j = 0; j < fc_pkg::OUT_COUNT; j++) begin : g_lane
        assign lanes[j].load       = load_q;
        assign lanes[j].feature    = lane_feature;
        assign lanes[j].weight_row = {rows[2*j+1], rows[2*j]};
        assign lanes[j].bias       = lane_bias[j*fc_pkg::BYTE_W +: fc_pkg::BYTE_W];
    end

endmodule

//--- source/fc_weight_ram.sv
// Weight word memory with a two-stage registered read, used by the loader to stage a frame's weights
`timescale 1ns/1ps

module fc_weight_ram (
    input  logic          clk,
    input  logic          rstn,
    input  logic          rd_en,
    input  logic          wr_en,
    input  fc_pkg::addr_t addr,
    input  fc_pkg::word_t wr_data,
    output fc_pkg::word_t rd_data
);

    // Storage, one word per weight row half
    fc_pkg::word_t mem [fc_pkg::WEIGHT_WORDS];

    // First read stage and its valid flag
    fc_pkg::word_t rd_stage;
    logic          rd_stage_vld;

    // Write lands on the edge it is presented
    // Read goes array -> stage -> output register
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
        if (rd_en) begin
            rd_stage <= mem[addr];
        end
        // Output only moves when a read is in flight
        if (rd_stage_vld) begin
            rd_data <= rd_stage;
        end
    end

    // Tracks a read between the two stages
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_stage_vld <= 1'b0;
        end else begin
            rd_stage_vld <= rd_en;
        end
    end

endmodule

//--- source/fc_lane_if.sv
// One neuron lane's load data from the loader and its result toward the output packer
`timescale 1ns/1ps

interface fc_lane_if;

    // Load side, all fields valid while load is high
    logic          load;
    fc_pkg::vec_t  feature;
    fc_pkg::vec_t  weight_row;
    logic [fc_pkg::BYTE_W-1:0] bias;

    // Result side, result valid while result_valid is high
    logic          result_valid;
    logic [fc_pkg::BYTE_W-1:0] result;

    // Frame loader drives a lane
    modport loader (
        output load,
        output feature,
        output weight_row,
        output bias
    );

    // Lane consumes the load and returns a byte
    modport neuron (
        input  load,
        input  feature,
        input  weight_row,
        input  bias,
        output result_valid,
        output result
    );

    // Output packer collects results
    modport pack (
        input result_valid,
        input result
    );

endinterface

//--- source/fc_pkg.sv
// Shared sizes, latencies, state encodings and data types of the FC layer, referenced by scoped names
package fc_pkg;

    //////////////////////////////////////////////////////////////////////
    // Layer geometry
    //////////////////////////////////////////////////////////////////////

    // Width of a feature, weight, bias or result byte
    localparam int BYTE_W = 8;
    // Input features per frame
    localparam int IN_COUNT = 8;
    // Output neurons, one lane each
    localparam int OUT_COUNT = 4;
    // Stream word width
    localparam int WORD_W = 32;

    // Frame layout in stream words
    localparam int INPUT_WORDS = 2;
    localparam int WEIGHT_WORDS = 8;
    // Features, weights, then one bias word
    localparam int FRAME_WORDS = INPUT_WORDS + WEIGHT_WORDS + 1;

    // Weight memory read latency in cycles
    localparam int MEM_LATENCY = 2;

    // Exact accumulator width and requantization shift
    localparam int ACC_W = 20;
    localparam int QUANT_SHIFT = 8;

    //////////////////////////////////////////////////////////////////////
    // Data types
    //////////////////////////////////////////////////////////////////////

    typedef logic [WORD_W-1:0] word_t;
    // Eight bytes, byte k at bits 8k+7..8k
    typedef logic [IN_COUNT*BYTE_W-1:0] vec_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    // Weight memory word address
    typedef logic [$clog2(WEIGHT_WORDS)-1:0] addr_t;

    // Loader FSM: idle receive, issuing reads, waiting for returns
    typedef enum logic [1:0] {
        RECEIVE,
        READBACK,
        LOAD
    } loader_state_e;

    // Neuron FSM
    typedef enum logic [1:0] {
        IDLE,
        ACCUMULATE,
        BIAS_ADD
    } neuron_state_e;

endpackage
